// File: verilog/display_pkg.sv
// ##############################
// Raster geometry, colours and pixel path structs
// Imported by scanner, painters, mixer and top
// ##############################
`default_nettype none

package display_pkg;

    localparam int coord_x_w = 10;        // Pixel x width
    localparam int coord_y_w = 9;         // Pixel y width
    localparam int h_active = 640;        // Visible columns
    localparam int v_active = 480;        // Visible lines
    localparam int reg_count = 8;         // Displayed registers

    // Box layout, one column per register
    localparam int box_w = 64;
    localparam int box_h = 38;
    localparam int x_start = 40;          // Top-left of first label box
    localparam int y_start = 40;
    localparam int col_spacing = 72;      // Column pitch
    localparam int text_x_off = 10;       // Digit position inside a box
    localparam int text_y_off = 10;
    localparam int char_w = 5;            // Glyph cell size
    localparam int char_h = 7;

    // 9-bit colour, 3R 3G 3B
    localparam int color_w = 9;
    localparam logic [color_w-1:0] line_color = 9'b111_111_111;
    localparam logic [color_w-1:0] data_color = 9'b111_000_000;
    localparam logic [color_w-1:0] label_color = 9'b000_111_000;
    localparam logic [color_w-1:0] back_color = 9'b000_000_000;

    typedef struct packed {
        logic [coord_x_w-1:0] x;
        logic [coord_y_w-1:0] y;
        logic                 valid;
    } coord_t;

    // Painter result handed to the mixer
    typedef struct packed {
        logic   line;
        logic   glyph;
        coord_t coord;
    } paint_t;

    typedef struct packed {
        logic [coord_x_w-1:0] x;
        logic [coord_y_w-1:0] y;
        logic [color_w-1:0]   color;
        logic                 plot;
    } pixel_t;

    // Column number under x, only meaningful inside a column
    function automatic logic [3:0] col_index(input logic [coord_x_w-1:0] x);
        return 4'((x - coord_x_w'(x_start)) / coord_x_w'(col_spacing));
    endfunction

    // Distance from the column's left edge
    function automatic logic [coord_x_w-1:0] col_offset(input logic [coord_x_w-1:0] x);
        return (x - coord_x_w'(x_start)) % coord_x_w'(col_spacing);
    endfunction

    // x lies inside one of the box columns
    function automatic logic in_column(input logic [coord_x_w-1:0] x);
        return (x >= coord_x_w'(x_start)) && (col_index(x) < 4'(reg_count))
            && (col_offset(x) < coord_x_w'(box_w));
    endfunction

endpackage

`default_nettype wire

// File: verilog/bus_pkg.sv
// ##############################
// Wishbone structs and register file type
// ##############################
`default_nettype none

package bus_pkg;

    localparam int wb_adr_w = 3;   // Eight registers
    localparam int wb_dat_w = 8;
    localparam int reg_w = 4;      // Stored bits per register

    // Master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    // All registers side by side, R0 in the low nibble
    typedef logic [2**wb_adr_w-1:0][reg_w-1:0] reg_file_t;

endpackage

`default_nettype wire

// File: verilog/reg_bank.sv
// ##############################
// Wishbone classic slave with eight 4-bit registers
// All values also driven out in parallel for display
// ##############################
`timescale 1ns/1ns
`default_nettype none

module reg_bank (
    input  logic               clock_50,
    input  logic               rst_n,
    input  bus_pkg::wb_req_t   wb_req,
    output bus_pkg::wb_rsp_t   wb_rsp,
    output bus_pkg::reg_file_t regs
);

    import bus_pkg::*;

    reg_file_t           regs_q;   // Register storage
    logic                ack_q;
    logic [wb_dat_w-1:0] dat_q;    // Read data, valid with ack
    logic                access;   // New cycle accepted this clock

    // Hold off while ack is up so each ack lasts one cycle
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            regs_q <= '0;
        end else begin
            ack_q <= access;           // Ack one clock after request
            if (access && wb_req.we) begin
                regs_q[wb_req.adr] <= wb_req.dat[reg_w-1:0]; // Low nibble only
            end
        end
    end

    // Read path, zero-extended register value
    always_ff @(posedge clock_50) begin
        if (access) begin
            dat_q <= wb_dat_w'(regs_q[wb_req.adr]);
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};
    assign regs   = regs_q;            // Parallel view for the value painter

endmodule

`default_nettype wire

// File: verilog/scan_counter.sv
// ##############################
// Raster scanner, one coordinate per clock
// ##############################
`timescale 1ns/1ns
`default_nettype none

module scan_counter #(
    parameter int h_active = display_pkg::h_active,
    parameter int v_active = display_pkg::v_active
) (
    input  logic                clock_50,
    input  logic                rst_n,
    output display_pkg::coord_t coord
);

    import display_pkg::*;

    logic [coord_x_w-1:0] x_q;
    logic [coord_y_w-1:0] y_q;
    logic                 valid_q;
    logic                 end_of_line;   // Last pixel of a line
    logic                 end_of_frame;  // Last line of the frame

    assign end_of_line  = (x_q == coord_x_w'(h_active - 1));
    assign end_of_frame = (y_q == coord_y_w'(v_active - 1));

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            x_q     <= '0;
            y_q     <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;            // Free-running once out of reset
            if (valid_q) begin          // First coordinate is (0, 0)
                if (end_of_line) begin
                    x_q <= '0;
                    // Next line, or back to top
                    y_q <= end_of_frame ? '0 : y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    assign coord = '{x: x_q, y: y_q, valid: valid_q};

endmodule

`default_nettype wire

// File: verilog/seven_seg_glyph.sv
// ##############################
// Seven-segment hex glyph test for one pixel
// Combinational, used by both painters
// ##############################
`timescale 1ns/1ns
`default_nettype none

module seven_seg_glyph (
    input  logic [display_pkg::coord_x_w-1:0] x_in,
    input  logic [display_pkg::coord_y_w-1:0] y_in,
    input  logic [display_pkg::coord_x_w-1:0] x_origin,
    input  logic [display_pkg::coord_y_w-1:0] y_origin,
    input  logic [3:0]                        digit,
    output logic                              draw_pixel
);

    import display_pkg::*;

    logic [coord_x_w-1:0] lx;      // Cell-local x
    logic [coord_y_w-1:0] ly;      // Cell-local y
    logic                 in_cell;
    logic [2:0]           cx, cy;  // Short local coords, valid inside the cell
    logic                 mid_x, upper_y, lower_y;
    logic [6:0]           seg_hit; // Pixel lies on segment, a at bit 6
    logic [6:0]           seg_on;  // Segments lit for the digit

    always_comb begin
        lx      = x_in - x_origin;   // Wraps large when left of origin
        ly      = y_in - y_origin;
        in_cell = (lx < coord_x_w'(char_w)) && (ly < coord_y_w'(char_h));
        cx      = lx[2:0];
        cy      = ly[2:0];
        mid_x   = (cx >= 3'd1) && (cx <= 3'd3);
        upper_y = (cy >= 3'd1) && (cy <= 3'd3);
        lower_y = (cy >= 3'd4) && (cy <= 3'd6);

        seg_hit[6] = (cy == 3'd0) && mid_x;    // a
        seg_hit[5] = (cx == 3'd4) && upper_y;  // b
        seg_hit[4] = (cx == 3'd4) && lower_y;  // c
        seg_hit[3] = (cy == 3'd6) && mid_x;    // d
        seg_hit[2] = (cx == 3'd0) && lower_y;  // e
        seg_hit[1] = (cx == 3'd0) && upper_y;  // f
        seg_hit[0] = (cy == 3'd3) && mid_x;    // g
    end

    // Hex decode, bit order a b c d e f g
    always_comb begin
        case (digit)
            4'h0: seg_on = 7'b111_1110;
            4'h1: seg_on = 7'b011_0000;
            4'h2: seg_on = 7'b110_1101;
            4'h3: seg_on = 7'b111_1001;
            4'h4: seg_on = 7'b011_0011;
            4'h5: seg_on = 7'b101_1011;
            4'h6: seg_on = 7'b101_1111;
            4'h7: seg_on = 7'b111_0000;
            4'h8: seg_on = 7'b111_1111;
            4'h9: seg_on = 7'b111_1011;
            4'hA: seg_on = 7'b111_0111;
            4'hB: seg_on = 7'b001_1111; // Lower case b
            4'hC: seg_on = 7'b100_1110;
            4'hD: seg_on = 7'b011_1101; // Lower case d
            4'hE: seg_on = 7'b100_1111;
            default: seg_on = 7'b100_0111; // F
        endcase
    end

    assign draw_pixel = in_cell && |(seg_hit & seg_on);

endmodule

`default_nettype wire

// File: verilog/label_painter.sv
// ##############################
// Box outlines and register index digits
// One clock from coordinate to paint result
// ##############################
`timescale 1ns/1ns
`default_nettype none

module label_painter (
    input  logic                clock_50,
    input  logic                rst_n,
    input  display_pkg::coord_t coord,
    output display_pkg::paint_t paint
);

    import display_pkg::*;

    // Row limits of the label box and the data box below it
    localparam logic [coord_y_w-1:0] label_top = coord_y_w'(y_start);
    localparam logic [coord_y_w-1:0] label_bot = coord_y_w'(y_start + box_h - 1);
    localparam logic [coord_y_w-1:0] data_top = coord_y_w'(y_start + box_h);
    localparam logic [coord_y_w-1:0] data_bot = coord_y_w'(y_start + 2 * box_h - 1);
    localparam logic [coord_y_w-1:0] glyph_y = coord_y_w'(y_start + text_y_off);

    logic [3:0]           col;       // Column index, doubles as the digit
    logic [coord_x_w-1:0] off;       // Offset inside the column
    logic [coord_x_w-1:0] glyph_x;   // Glyph cell origin
    logic                 in_col, in_rows, edge_x, edge_y;
    logic                 glyph_px;
    logic                 line_q, glyph_q, valid_q;
    logic [coord_x_w-1:0] x_q;
    logic [coord_y_w-1:0] y_q;

    always_comb begin
        col     = col_index(coord.x);
        off     = col_offset(coord.x);
        in_col  = in_column(coord.x);
        in_rows = (coord.y >= label_top) && (coord.y <= data_bot);
        edge_x  = (off == '0) || (off == coord_x_w'(box_w - 1));   // Left or right side
        edge_y  = (coord.y == label_top) || (coord.y == label_bot)
               || (coord.y == data_top) || (coord.y == data_bot);
        glyph_x = coord.x - off + coord_x_w'(text_x_off);
    end

    seven_seg_glyph i_glyph (
        .x_in       (coord.x),
        .y_in       (coord.y),
        .x_origin   (glyph_x),
        .y_origin   (glyph_y),
        .digit      (col),
        .draw_pixel (glyph_px)
    );

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            line_q  <= 1'b0;
            glyph_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            line_q  <= coord.valid && in_col && in_rows && (edge_x || edge_y);
            glyph_q <= coord.valid && in_col && glyph_px;   // Outside columns col is junk
            valid_q <= coord.valid;
        end
    end

    always_ff @(posedge clock_50) begin
        x_q <= coord.x;
        y_q <= coord.y;
    end

    assign paint = '{line: line_q, glyph: glyph_q, coord: '{x: x_q, y: y_q, valid: valid_q}};

endmodule

`default_nettype wire

// File: verilog/value_painter.sv
// ##############################
// Register value digits in the data boxes
// One clock from coordinate to paint result
// ##############################
`timescale 1ns/1ns
`default_nettype none

module value_painter (
    input  logic                clock_50,
    input  logic                rst_n,
    input  display_pkg::coord_t coord,
    input  bus_pkg::reg_file_t  regs,
    output display_pkg::paint_t paint
);

    import display_pkg::*;

    // Digit row sits in the data box, one box height below the label
    localparam logic [coord_y_w-1:0] glyph_y = coord_y_w'(y_start + box_h + text_y_off);

    logic [3:0]           col;
    logic [coord_x_w-1:0] off;
    logic [coord_x_w-1:0] glyph_x;
    logic [3:0]           digit;     // Contents of this column's register
    logic                 in_col;
    logic                 glyph_px;
    logic                 glyph_q, valid_q;
    logic [coord_x_w-1:0] x_q;
    logic [coord_y_w-1:0] y_q;

    always_comb begin
        col     = col_index(coord.x);
        off     = col_offset(coord.x);
        in_col  = in_column(coord.x);
        digit   = regs[col[2:0]];       // In range whenever in_col is set
        glyph_x = coord.x - off + coord_x_w'(text_x_off);
    end

    seven_seg_glyph i_glyph (
        .x_in       (coord.x),
        .y_in       (coord.y),
        .x_origin   (glyph_x),
        .y_origin   (glyph_y),
        .digit      (digit),
        .draw_pixel (glyph_px)
    );

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            glyph_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            glyph_q <= coord.valid && in_col && glyph_px;
            valid_q <= coord.valid;
        end
    end

    always_ff @(posedge clock_50) begin
        x_q <= coord.x;
        y_q <= coord.y;
    end

    // Outlines come from the label painter
    assign paint = '{line: 1'b0, glyph: glyph_q, coord: '{x: x_q, y: y_q, valid: valid_q}};

endmodule

`default_nettype wire

// File: verilog/pixel_mixer.sv
// ##############################
// Colour priority and registered pixel output
// ##############################
`timescale 1ns/1ns
`default_nettype none

module pixel_mixer (
    input  logic                clock_50,
    input  logic                rst_n,
    input  display_pkg::paint_t label_paint,
    input  display_pkg::paint_t value_paint,
    output display_pkg::pixel_t pixel
);

    import display_pkg::*;

    logic [color_w-1:0]   color_d;
    logic [color_w-1:0]   color_q;
    logic                 plot_q;
    logic [coord_x_w-1:0] x_q;
    logic [coord_y_w-1:0] y_q;

    // First match wins
    always_comb begin
        if (label_paint.line || value_paint.line) begin
            color_d = line_color;
        end else if (value_paint.glyph) begin
            color_d = data_color;       // Value beats label
        end else if (label_paint.glyph) begin
            color_d = label_color;
        end else begin
            color_d = back_color;
        end
    end

    always_ff @(posedge clock_50) begin
        if (!rst_n) begin
            color_q <= back_color;
            plot_q  <= 1'b0;
        end else begin
            color_q <= color_d;
            plot_q  <= label_paint.coord.valid && value_paint.coord.valid; // Painters in step
        end
    end

    always_ff @(posedge clock_50) begin
        x_q <= label_paint.coord.x;
        y_q <= label_paint.coord.y;
    end

    assign pixel = '{x: x_q, y: y_q, color: color_q, plot: plot_q};

endmodule

`default_nettype wire

// File: verilog/reg_display_top.sv
// ##############################
// Register display top, bus slave in, pixel stream out
// Pixel appears two clocks after its coordinate
// ##############################
`timescale 1ns/1ns
`default_nettype none

module reg_display_top #(
    parameter int h_active = display_pkg::h_active,
    parameter int v_active = display_pkg::v_active
) (
    input  logic                clock_50,
    input  logic                rst_n,
    input  bus_pkg::wb_req_t    wb_req,
    output bus_pkg::wb_rsp_t    wb_rsp,
    output display_pkg::pixel_t pixel
);

    import display_pkg::*;
    import bus_pkg::*;

    reg_file_t regs;         // Register contents for display
    coord_t    coord;        // Current scan position
    paint_t    label_paint;
    paint_t    value_paint;

    reg_bank i_reg_bank (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .regs     (regs)
    );

    scan_counter #(
        .h_active (h_active),
        .v_active (v_active)
    ) i_scan_counter (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .coord    (coord)
    );

    // Both painters see the same coordinate and stay aligned
    label_painter i_label_painter (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .coord    (coord),
        .paint    (label_paint)
    );

    value_painter i_value_painter (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .coord    (coord),
        .regs     (regs),
        .paint    (value_paint)
    );

    pixel_mixer i_pixel_mixer (
        .clock_50    (clock_50),
        .rst_n       (rst_n),
        .label_paint (label_paint),
        .value_paint (value_paint),
        .pixel       (pixel)
    );

endmodule

`default_nettype wire

// File: tests/reg_display_checker.sv
// ##############################
// Bus and pixel assertions, bound into the display top
// ##############################
`timescale 1ns/1ns
`default_nettype none

module reg_display_checker (
    input logic                clock_50,
    input logic                rst_n,
    input bus_pkg::wb_req_t    wb_req,
    input bus_pkg::wb_rsp_t    wb_rsp,
    input display_pkg::pixel_t pixel
);

    import display_pkg::*;

    // Slave answers only inside an active cycle
    ack_in_cycle: assert property (@(posedge clock_50) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack seen outside a bus cycle");

    ack_single: assert property (@(posedge clock_50) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)   // One-cycle ack
        else $error("ack held for two cycles");

    // Reset is synchronous, so plot drops one edge later
    plot_in_reset: assert property (@(posedge clock_50)
        !rst_n |=> !pixel.plot)
        else $error("plot high during reset");

    color_legal: assert property (@(posedge clock_50) disable iff (!rst_n)
        (pixel.color == line_color) || (pixel.color == data_color)
        || (pixel.color == label_color) || (pixel.color == back_color))
        else $error("pixel colour outside the palette");

endmodule

bind reg_display_top reg_display_checker i_checker (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .pixel    (pixel)
);

`default_nettype wire

// File: tests/reg_display_tb.sv
// ##############################
// Testbench for the register display, run as top
// Bus writes, pixel probes against a drawing model
// ##############################
`timescale 1ns/1ns
`default_nettype none

module reg_display_tb;

    import display_pkg::*;
    import bus_pkg::*;

    localparam int ack_limit = 16;          // Clocks to wait for ack
    localparam int probe_limit = 320000;    // A little over one frame
    localparam int entry_count = 16;
    // Per segment a..g, bit n set when hex digit n lights it
    localparam logic [15:0] seg_digits [7] = '{16'hD7ED, 16'h279F, 16'h2FFB, 16'h7B6D,
                                               16'hFD45, 16'hDF71, 16'hEF7C};

    typedef struct packed {
        logic [2:0] idx;     // Register written before the probe
        logic [4:0] val;     // 16 draws a value from the LFSR
        logic [9:0] px;
        logic [8:0] py;
        logic [8:0] color;   // Expected colour at (px, py)
    } entry_t;

    logic            clock_50 = 1'b0;   // Low from time zero
    logic            rst_n;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    pixel_t          pixel;
    entry_t          stim [entry_count];
    logic [7:0][3:0] shadow;     // Expected register contents
    logic [15:0]     lfsr_q;
    int              errors, checks, tests;

    reg_display_top #(
        .h_active (640),
        .v_active (480)
    ) i_dut (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .pixel    (pixel)
    );

    initial begin
        forever #5 clock_50 = ~clock_50;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_nibble(output logic [3:0] v);
        logic [3:0] acc;
        acc = 4'h0;
        for (int i = 0; i < 4; i++) begin
            lfsr_q = lfsr_next(lfsr_q);   // One step per bit
            acc = {acc[2:0], lfsr_q[0]};
        end
        v = acc;
    endtask

    // Cell-local pixel on a segment that the digit lights
    function automatic logic glyph_lit(input int lx, input int ly, input logic [3:0] digit);
        logic [6:0] on_seg;
        logic       mid_x;
        logic       hit;
        hit   = 1'b0;
        mid_x = (lx >= 1) && (lx <= 3);
        on_seg[0] = mid_x && (ly == 0);                    // a
        on_seg[1] = (lx == 4) && (ly >= 1) && (ly <= 3);   // b
        on_seg[2] = (lx == 4) && (ly >= 4) && (ly <= 6);   // c
        on_seg[3] = mid_x && (ly == 6);                    // d
        on_seg[4] = (lx == 0) && (ly >= 4) && (ly <= 6);   // e
        on_seg[5] = (lx == 0) && (ly >= 1) && (ly <= 3);   // f
        on_seg[6] = mid_x && (ly == 3);                    // g
        for (int s = 0; s < 7; s++) begin
            hit = hit | (on_seg[s] & seg_digits[s][digit]);
        end
        return hit;
    endfunction

    function automatic logic [8:0] expected_color(input int x, input int y,
                                                  input logic [7:0][3:0] regs_m);
        int   x0;
        logic is_line, val_hit, lab_hit;
        is_line = 1'b0;
        val_hit = 1'b0;
        lab_hit = 1'b0;
        for (int i = 0; i < 8; i++) begin
            x0 = 40 + 72 * i;
            if (x >= x0 && x <= x0 + 63) begin
                // Label box rows 40..77, data box rows 78..115
                is_line = (y >= 40) && (y <= 115) && ((x == x0) || (x == x0 + 63)
                          || (y == 40) || (y == 77) || (y == 78) || (y == 115));
                val_hit = glyph_lit(x - x0 - 10, y - 88, regs_m[i]);
                lab_hit = glyph_lit(x - x0 - 10, y - 50, 4'(i));
            end
        end
        if (is_line) return line_color;
        else if (val_hit) return data_color;
        else if (lab_hit) return label_color;
        else return back_color;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic log_test(input string name, input int err_start);
        tests++;
        $display("%s: %s", name, (errors == err_start) ? "ok" : "failed");
    endtask

    // One classic cycle; request stays up through the edge that samples ack
    task automatic run_cycle(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata);
        int n;
        n = 0;
        rdata = 8'h00;
        @(negedge clock_50);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clock_50);
            n++;
        end while (!wb_rsp.ack && n < ack_limit);
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat;
        end else begin
            errors++;
            $display("Timeout: no ack from R%0d within %0d clocks", adr, ack_limit);
        end
        @(negedge clock_50);
        wb_req = '0;
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [7:0] dat);
        logic [7:0] unused_rd;
        run_cycle(1'b1, adr, dat, unused_rd);
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [7:0] rd);
        run_cycle(1'b0, adr, 8'h00, rd);
    endtask

    task automatic wait_for_pixel(input int px, input int py, output logic found);
        int n;
        n = 0;
        found = 1'b0;
        while (!found && n < probe_limit) begin
            @(negedge clock_50);
            n++;
            found = pixel.plot && (int'(pixel.x) == px) && (int'(pixel.y) == py);
        end
        if (!found) begin
            errors++;
            $display("Timeout: pixel (%0d, %0d) never reached the output", px, py);
        end
    endtask

    function automatic entry_t make_entry(input int idx, input int val, input int px,
                                          input int py);
        return '{idx: 3'(idx), val: 5'(val), px: 10'(px), py: 9'(py), color: 9'h000};
    endfunction

    // Random values drawn and colours predicted in application order
    task automatic build_table();
        logic [7:0][3:0] model;
        logic [3:0]      v;
        model = shadow;
        stim[0]  = make_entry(3, 16, 256, 60);   // Column 3 left border
        stim[1]  = make_entry(3, 16, 300, 77);   // Label box bottom
        stim[2]  = make_entry(3, 16, 280, 100);  // Data box interior
        stim[3]  = make_entry(0, 16, 51, 50);    // Label 0, segment a
        stim[4]  = make_entry(0, 16, 51, 53);    // Label 0, segment g
        stim[5]  = make_entry(6, 16, 484, 53);   // Label 6, segment g
        stim[6]  = make_entry(5, 1, 414, 89);    // Value 1, segment b
        stim[7]  = make_entry(5, 1, 411, 88);    // Value 1, segment a
        stim[8]  = make_entry(5, 1, 414, 92);    // Value 1, segment c
        stim[9]  = make_entry(5, 8, 411, 88);    // Rewrite lights a
        stim[10] = make_entry(2, 16, 196, 91);
        stim[11] = make_entry(7, 16, 554, 93);
        stim[12] = make_entry(1, 16, 124, 94);
        stim[13] = make_entry(4, 16, 342, 90);
        stim[14] = make_entry(4, 16, 391, 78);   // Right border at box seam
        stim[15] = make_entry(6, 16, 600, 300);  // Below the boxes
        for (int e = 0; e < entry_count; e++) begin
            if (stim[e].val[4]) begin
                draw_nibble(v);
                stim[e].val = {1'b0, v};
            end
            model[stim[e].idx] = stim[e].val[3:0];
            stim[e].color = expected_color(int'(stim[e].px), int'(stim[e].py), model);
        end
    endtask

    // Follow the stream for four clocks from a known pixel
    task automatic follow_scan(input int x0, input int y0);
        int   ex, ey;
        logic found;
        wait_for_pixel(x0, y0, found);
        ex = x0;
        ey = y0;
        for (int k = 1; k < 5 && found; k++) begin
            ey = (ex == 639) ? ((ey == 479) ? 0 : ey + 1) : ey;
            ex = (ex == 639) ? 0 : ex + 1;
            @(negedge clock_50);
            compare_value("pixel.x", 32'(pixel.x), 32'(ex));
            compare_value("pixel.y", 32'(pixel.y), 32'(ey));
            compare_value("pixel.plot", 32'(pixel.plot), 32'd1);
        end
    endtask

    initial begin
        int         err_start;
        logic [7:0] rd;
        logic [3:0] v;
        logic       found;
        errors = 0;
        checks = 0;
        tests  = 0;
        lfsr_q = 16'd42727;
        shadow = '0;
        rst_n  = 1'b0;
        wb_req = '0;

        err_start = errors;
        repeat (4) begin
            @(negedge clock_50);
            compare_value("pixel.plot", 32'(pixel.plot), 32'd0);
            compare_value("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);
        end
        rst_n = 1'b1;
        @(negedge clock_50);
        compare_value("pixel.plot", 32'(pixel.plot), 32'd0);   // Pipeline still filling
        for (int a = 0; a < 8; a++) begin
            read_reg(3'(a), rd);
            compare_value($sformatf("R%0d", a), 32'(rd), 32'd0);
        end
        log_test("Reset", err_start);

        err_start = errors;
        for (int a = 0; a < 8; a++) begin
            draw_nibble(v);
            write_reg(3'(a), {~v, v});   // High nibble must be dropped
            shadow[a] = v;
            read_reg(3'(a), rd);
            compare_value($sformatf("R%0d", a), 32'(rd), 32'({4'h0, v}));
        end
        for (int a = 0; a < 8; a++) begin
            read_reg(3'(a), rd);
            compare_value($sformatf("R%0d", a), 32'(rd), 32'({4'h0, shadow[a]}));
        end
        log_test("Register read and write", err_start);

        build_table();
        for (int e = 0; e < entry_count; e++) begin
            err_start = errors;
            write_reg(stim[e].idx, {3'b000, stim[e].val});
            repeat (2) @(negedge clock_50);   // Drain pixels painted before the write
            wait_for_pixel(int'(stim[e].px), int'(stim[e].py), found);
            if (found) begin
                compare_value("pixel.color", 32'(pixel.color), 32'(stim[e].color));
            end
            log_test($sformatf("Entry %0d R%0d=0x%0h at (%0d, %0d)", e, stim[e].idx,
                               stim[e].val, stim[e].px, stim[e].py), err_start);
        end

        err_start = errors;
        follow_scan(637, 10);    // Line wrap
        follow_scan(638, 479);   // Frame wrap
        log_test("Scan stream", err_start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/display_pkg.sv
verilog/bus_pkg.sv
verilog/reg_bank.sv
verilog/scan_counter.sv
verilog/seven_seg_glyph.sv
verilog/label_painter.sv
verilog/value_painter.sv
verilog/pixel_mixer.sv
verilog/reg_display_top.sv
tests/reg_display_checker.sv
tests/reg_display_tb.sv

// File: Makefile
# Verilator flow for the register display testbench

VERILATOR ?= verilator
TOP       ?= reg_display_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
